/* serial_rf.f */
src/serial_rf_pkg.sv
src/lane_bus.sv
src/rf_ram.sv
src/rf_ram_if.sv
src/serial_lane.sv
src/cmd_dispatch.sv
src/result_collect.sv
src/serial_rf_top.sv
verif/tb_serial_rf.sv

/* src/cmd_dispatch.sv */
`timescale 1ns/1ps

module cmd_dispatch #(
   parameter int N_LANES = 4
) (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_cmd_req,
   input  logic [$clog2(N_LANES)-1:0]   i_cmd_lane,
   input  serial_rf_pkg::op_t           i_cmd_op,
   input  serial_rf_pkg::reg_idx_t      i_cmd_rd,
   input  serial_rf_pkg::reg_idx_t      i_cmd_rs1,
   input  serial_rf_pkg::reg_idx_t      i_cmd_rs2,
   input  serial_rf_pkg::word_t         i_cmd_imm,
   output logic                         o_cmd_ack,
   cmd_bus.disp                         cmd [N_LANES]
);
   import serial_rf_pkg::*;

   localparam int LANE_W = $clog2(N_LANES);

   typedef logic [LANE_W-1:0] lane_id_t;
   typedef enum logic [1:0] {D_IDLE, D_REQ, D_ACK} disp_state_t;

   disp_state_t        state;
   lane_id_t           sel;
   op_t                op_r;
   reg_idx_t           rd_r;
   reg_idx_t           rs1_r;
   reg_idx_t           rs2_r;
   word_t              imm_r;
   logic [N_LANES-1:0] lane_ack;

   // every lane sees the same payload, only the selected one sees req
   for (genvar g = 0; g < N_LANES; g++) begin : g_lane
      assign cmd[g].req = (state == D_REQ) && (sel == lane_id_t'(g));
      assign cmd[g].op  = op_r;
      assign cmd[g].rd  = rd_r;
      assign cmd[g].rs1 = rs1_r;
      assign cmd[g].rs2 = rs2_r;
      assign cmd[g].imm = imm_r;
      assign lane_ack[g] = cmd[g].ack;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state     <= D_IDLE;
         sel       <= '0;
         o_cmd_ack <= 1'b0;
      end else begin
         case (state)
            D_IDLE: begin
               if (i_cmd_req) begin
                  sel   <= i_cmd_lane;
                  state <= D_REQ;
               end
            end
            D_REQ: begin
               // a busy lane holds off its ack
               if (lane_ack[sel]) begin
                  o_cmd_ack <= 1'b1;
                  state     <= D_ACK;
               end
            end
            D_ACK: begin
               if (!i_cmd_req && !lane_ack[sel]) begin
                  o_cmd_ack <= 1'b0;
                  state     <= D_IDLE;
               end
            end
            default: state <= D_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == D_IDLE && i_cmd_req) begin
         op_r  <= i_cmd_op;
         rd_r  <= i_cmd_rd;
         rs1_r <= i_cmd_rs1;
         rs2_r <= i_cmd_rs2;
         imm_r <= i_cmd_imm;
      end
   end

   a_lane_range: assert property (@(posedge i_clk) disable iff (i_rst)
      $rose(i_cmd_req) |-> i_cmd_lane < N_LANES)
      else $error("cmd_dispatch: command for lane %0d out of range", i_cmd_lane);

endmodule

/* src/lane_bus.sv */
`timescale 1ns/1ps

// command channel, dispatcher to one lane, four-phase req/ack
interface cmd_bus;
   import serial_rf_pkg::*;

   logic     req;
   logic     ack;
   op_t      op;
   reg_idx_t rd;
   reg_idx_t rs1;
   reg_idx_t rs2;
   word_t    imm;

   modport disp (output req, output op, output rd, output rs1, output rs2, output imm,
                 input ack);
   modport lane (input req, input op, input rd, input rs1, input rs2, input imm,
                 output ack);
endinterface

// result channel, one lane to the collector, four-phase req/ack
interface res_bus;
   import serial_rf_pkg::*;

   logic  req;
   logic  ack;
   word_t data;

   modport lane (output req, output data, input ack);
   modport coll (input req, input data, output ack);
endinterface

/* src/result_collect.sv */
`timescale 1ns/1ps

module result_collect #(
   parameter int N_LANES = 4
) (
   input  logic                       i_clk,
   input  logic                       i_rst,
   res_bus.coll                       res [N_LANES],
   output logic                       o_res_req,
   input  logic                       i_res_ack,
   output logic [$clog2(N_LANES)-1:0] o_res_lane,
   output serial_rf_pkg::word_t       o_res_data
);
   import serial_rf_pkg::*;

   localparam int LANE_W = $clog2(N_LANES);

   typedef logic [LANE_W-1:0] lane_id_t;
   typedef enum logic {C_IDLE, C_BUSY} coll_state_t;

   coll_state_t        state;
   lane_id_t           last;
   lane_id_t           pick;
   logic               found;
   logic               lane_ack;
   logic [N_LANES-1:0] lane_req;
   word_t              lane_data [N_LANES];

   for (genvar g = 0; g < N_LANES; g++) begin : g_lane
      assign lane_req[g]  = res[g].req;
      assign lane_data[g] = res[g].data;
      assign res[g].ack   = lane_ack && (last == lane_id_t'(g));
   end

   // round-robin scan, starting one past the lane served last
   always_comb begin
      int idx;
      idx   = 0;
      found = 1'b0;
      pick  = last;
      for (int k = 1; k <= N_LANES; k++) begin
         idx = (int'(last) + k) % N_LANES;
         if (!found && lane_req[idx]) begin
            found = 1'b1;
            pick  = lane_id_t'(idx);
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state     <= C_IDLE;
         last      <= lane_id_t'(N_LANES - 1);
         lane_ack  <= 1'b0;
         o_res_req <= 1'b0;
      end else begin
         case (state)
            C_IDLE: begin
               if (found) begin
                  last      <= pick;
                  lane_ack  <= 1'b1;
                  o_res_req <= 1'b1;
                  state     <= C_BUSY;
               end
            end
            C_BUSY: begin
               // both handshakes close independently
               if (lane_ack && !lane_req[last]) begin
                  lane_ack <= 1'b0;
               end
               if (o_res_req && i_res_ack) begin
                  o_res_req <= 1'b0;
               end
               if (!lane_ack && !o_res_req && !i_res_ack) begin
                  state <= C_IDLE;
               end
            end
            default: state <= C_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == C_IDLE && found) begin
         o_res_data <= lane_data[pick];
         o_res_lane <= pick;
      end
   end

   a_res_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      o_res_req && $past(o_res_req) |-> $stable(o_res_data) && $stable(o_res_lane))
      else $error("result_collect: result changed while o_res_req high");

endmodule

/* src/rf_ram.sv */
`timescale 1ns/1ps

module rf_ram #(
   parameter int RAM_W = 8
) (
   input  logic                           i_clk,
   input  logic [$clog2(32*32/RAM_W)-1:0] i_waddr,
   input  logic [RAM_W-1:0]               i_wdata,
   input  logic                           i_wen,
   input  logic [$clog2(32*32/RAM_W)-1:0] i_raddr,
   output logic [RAM_W-1:0]               o_rdata
);
   localparam int DEPTH = 32 * 32 / RAM_W;

   logic [RAM_W-1:0] mem [DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata <= mem[i_raddr];
   end

endmodule

/* src/rf_ram_if.sv */
`timescale 1ns/1ps

module rf_ram_if #(
   parameter int RAM_W = 8
) (
   input  logic                                  i_clk,
   input  logic                                  i_rst,
   input  logic                                  i_wreq,
   input  logic                                  i_rreq,
   output logic                                  o_rgnt,
   input  serial_rf_pkg::reg_idx_t               i_wreg,
   input  logic                                  i_wen,
   input  logic                                  i_wdata,
   input  serial_rf_pkg::reg_idx_t               i_rreg0,
   input  serial_rf_pkg::reg_idx_t               i_rreg1,
   output logic                                  o_rdata0,
   output logic                                  o_rdata1,
   output logic [$clog2(32*32/RAM_W)-1:0]        o_waddr,
   output logic [RAM_W-1:0]                      o_wdata,
   output logic                                  o_wen,
   output logic [$clog2(32*32/RAM_W)-1:0]        o_raddr,
   input  logic [RAM_W-1:0]                      i_rdata
);
   import serial_rf_pkg::*;

   localparam int L2W = $clog2(RAM_W);

   logic [4:0]       wcnt;
   logic             wgo;
   logic             wreq_r;
   logic             wtrig;
   logic [RAM_W-2:0] wdata_r;

   logic [4:0]       rcnt;
   logic             rreq_r;
   logic             rtrig0;
   logic             rtrig1;
   reg_idx_t         rreg;
   logic [RAM_W-1:0] rdata0;
   logic [RAM_W-2:0] rdata1;

   // write one word once its last bit is on i_wdata
   assign wtrig   = (wcnt[L2W-1:0] == {L2W{1'b1}});
   assign o_wdata = {i_wdata, wdata_r};
   assign o_wen   = wgo & wtrig & i_wen;

   if (RAM_W == 32) begin : g_waddr_full
      assign o_waddr = i_wreg;
   end else begin : g_waddr_part
      assign o_waddr = {i_wreg, wcnt[4:L2W]};
   end

   if (RAM_W > 2) begin : g_wsr_wide
      always_ff @(posedge i_clk) begin
         wdata_r <= {i_wdata, wdata_r[RAM_W-2:1]};
      end
   end else begin : g_wsr_narrow
      always_ff @(posedge i_clk) begin
         wdata_r <= i_wdata;
      end
   end

   // bit 0 of the write stream arrives two cycles after wreq
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wcnt   <= 5'd0;
         wgo    <= 1'b0;
         wreq_r <= 1'b0;
      end else begin
         wreq_r <= i_wreq;
         if (wgo) begin
            wcnt <= wcnt + 5'd1;
         end
         if (wreq_r) begin
            wgo <= 1'b1;
         end else if (wgo && wcnt == 5'd31) begin
            wgo <= 1'b0;
         end
      end
   end

   // rs0 word fetched on even slots, rs1 word on the slot after
   assign rtrig0 = (rcnt[L2W-1:0] == L2W'(1));
   assign rreg   = rtrig0 ? i_rreg1 : i_rreg0;

   if (RAM_W == 32) begin : g_raddr_full
      assign o_raddr = rreg;
   end else begin : g_raddr_part
      assign o_raddr = {rreg, rcnt[4:L2W]};
   end

   assign o_rdata0 = rdata0[0];
   assign o_rdata1 = rtrig1 ? i_rdata[0] : rdata1[0];

   always_ff @(posedge i_clk) begin
      if (rtrig0) begin
         rdata0 <= i_rdata;
      end else begin
         rdata0 <= {1'b0, rdata0[RAM_W-1:1]};
      end
   end

   if (RAM_W > 2) begin : g_rsr_wide
      always_ff @(posedge i_clk) begin
         if (rtrig1) begin
            rdata1 <= i_rdata[RAM_W-1:1];
         end else begin
            rdata1 <= {1'b0, rdata1[RAM_W-2:1]};
         end
      end
   end else begin : g_rsr_narrow
      always_ff @(posedge i_clk) begin
         if (rtrig1) begin
            rdata1 <= i_rdata[1];
         end
      end
   end

   // grant two cycles after rreq, first read bit one cycle after grant
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rcnt   <= 5'd0;
         rtrig1 <= 1'b0;
         rreq_r <= 1'b0;
         o_rgnt <= 1'b0;
      end else begin
         rtrig1 <= rtrig0;
         rcnt   <= i_rreq ? 5'd0 : rcnt + 5'd1;
         rreq_r <= i_rreq;
         o_rgnt <= rreq_r;
      end
   end

   // serial write bits from the lane must fall inside the running write burst
   a_wen_in_burst: assert property (@(posedge i_clk) disable iff (i_rst)
      i_wen |-> wgo)
      else $error("rf_ram_if: serial write enable outside the write burst");

endmodule

/* src/serial_lane.sv */
`timescale 1ns/1ps

module serial_lane #(
   parameter int RAM_W = 8
) (
   input logic  i_clk,
   input logic  i_rst,
   cmd_bus.lane cmd,
   res_bus.lane res
);
   import serial_rf_pkg::*;

   localparam int AW = $clog2(32 * 32 / RAM_W);

   lane_state_t      state;
   logic             ack_r;
   logic             rreq;
   logic             wreq;
   logic             rgnt;
   logic             res_req;
   logic             carry;
   logic [4:0]       bit_cnt;
   op_t              op_r;
   reg_idx_t         rd_r;
   reg_idx_t         rs1_r;
   reg_idx_t         rs2_r;
   word_t            imm_sr;
   word_t            res_sr;
   logic             a;
   logic             b;
   logic             wbit;
   logic             wen;
   logic [AW-1:0]    waddr;
   logic [AW-1:0]    raddr;
   logic [RAM_W-1:0] ram_wdata;
   logic [RAM_W-1:0] ram_rdata;
   logic             ram_wen;

   assign cmd.ack  = ack_r;
   assign res.req  = res_req;
   assign res.data = res_sr;

   // bit-serial alu, a = rs1 bit, b = rs2 bit
   always_comb begin
      case (op_r)
         OP_LDI:  wbit = imm_sr[0];
         OP_ADD:  wbit = a ^ b ^ carry;
         OP_XOR:  wbit = a ^ b;
         default: wbit = 1'b0;
      endcase
   end

   assign wen = (state == ST_RUN) && (op_r != OP_RD);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state   <= ST_IDLE;
         ack_r   <= 1'b0;
         rreq    <= 1'b0;
         wreq    <= 1'b0;
         res_req <= 1'b0;
         carry   <= 1'b0;
         bit_cnt <= 5'd0;
      end else begin
         rreq <= 1'b0;
         wreq <= rreq;
         case (state)
            ST_IDLE: begin
               if (cmd.req && !ack_r) begin
                  ack_r <= 1'b1;
               end else if (!cmd.req && ack_r) begin
                  ack_r <= 1'b0;
                  rreq  <= 1'b1;
                  state <= ST_READ;
               end
            end
            ST_READ: begin
               bit_cnt <= 5'd0;
               carry   <= 1'b0;
               if (rgnt) begin
                  state <= ST_RUN;
               end
            end
            ST_RUN: begin
               bit_cnt <= bit_cnt + 5'd1;
               carry   <= (a & b) | (carry & (a ^ b));
               if (bit_cnt == 5'd31) begin
                  res_req <= (op_r == OP_RD);
                  state   <= ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               // hold here until the result handshake is fully done
               if (res_req) begin
                  if (res.ack) begin
                     res_req <= 1'b0;
                  end
               end else if (!res.ack) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == ST_IDLE && cmd.req && !ack_r) begin
         op_r   <= cmd.op;
         rd_r   <= cmd.rd;
         rs1_r  <= cmd.rs1;
         rs2_r  <= cmd.rs2;
         imm_sr <= cmd.imm;
      end else if (state == ST_RUN) begin
         imm_sr <= imm_sr >> 1;
      end
      if (state == ST_RUN) begin
         res_sr <= {a, res_sr[31:1]};
      end
   end

   rf_ram_if #(
      .RAM_W (RAM_W)
   ) rf_ram_if_inst (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wreq   (wreq),
      .i_rreq   (rreq),
      .o_rgnt   (rgnt),
      .i_wreg   (rd_r),
      .i_wen    (wen),
      .i_wdata  (wbit),
      .i_rreg0  (rs1_r),
      .i_rreg1  (rs2_r),
      .o_rdata0 (a),
      .o_rdata1 (b),
      .o_waddr  (waddr),
      .o_wdata  (ram_wdata),
      .o_wen    (ram_wen),
      .o_raddr  (raddr),
      .i_rdata  (ram_rdata)
   );

   rf_ram #(
      .RAM_W (RAM_W)
   ) rf_ram_inst (
      .i_clk   (i_clk),
      .i_waddr (waddr),
      .i_wdata (ram_wdata),
      .i_wen   (ram_wen),
      .i_raddr (raddr),
      .o_rdata (ram_rdata)
   );

   a_ack_idle: assert property (@(posedge i_clk) disable iff (i_rst)
      cmd.ack |-> state == ST_IDLE)
      else $error("serial_lane: command ack while busy");

   a_res_drain: assert property (@(posedge i_clk) disable iff (i_rst)
      res.req |-> state == ST_DRAIN)
      else $error("serial_lane: result req outside drain");

endmodule

/* src/serial_rf_pkg.sv */
package serial_rf_pkg;

   // one architectural register value
   typedef logic [31:0] word_t;

   // index into the 32 registers of a lane
   typedef logic [4:0] reg_idx_t;

   typedef logic [1:0] op_t;

   // rd <= imm
   localparam op_t OP_LDI = 2'd0;
   // rd <= rs1 + rs2, carry out dropped
   localparam op_t OP_ADD = 2'd1;
   // rd <= rs1 ^ rs2
   localparam op_t OP_XOR = 2'd2;
   // result <= rs1, no register write
   localparam op_t OP_RD  = 2'd3;

   // lane sequencing, one operation at a time
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_RUN,
      ST_DRAIN
   } lane_state_t;

endpackage

/* src/serial_rf_top.sv */
`timescale 1ns/1ps

module serial_rf_top #(
   parameter int N_LANES = 4,
   parameter int RAM_W   = 8
) (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  logic                       i_cmd_req,
   input  logic [$clog2(N_LANES)-1:0] i_cmd_lane,
   input  serial_rf_pkg::op_t         i_cmd_op,
   input  serial_rf_pkg::reg_idx_t    i_cmd_rd,
   input  serial_rf_pkg::reg_idx_t    i_cmd_rs1,
   input  serial_rf_pkg::reg_idx_t    i_cmd_rs2,
   input  serial_rf_pkg::word_t       i_cmd_imm,
   output logic                       o_cmd_ack,
   output logic                       o_res_req,
   output logic [$clog2(N_LANES)-1:0] o_res_lane,
   output serial_rf_pkg::word_t       o_res_data,
   input  logic                       i_res_ack
);

   cmd_bus cmd_if [N_LANES] ();
   res_bus res_if [N_LANES] ();

   cmd_dispatch #(
      .N_LANES (N_LANES)
   ) cmd_dispatch_inst (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_cmd_req  (i_cmd_req),
      .i_cmd_lane (i_cmd_lane),
      .i_cmd_op   (i_cmd_op),
      .i_cmd_rd   (i_cmd_rd),
      .i_cmd_rs1  (i_cmd_rs1),
      .i_cmd_rs2  (i_cmd_rs2),
      .i_cmd_imm  (i_cmd_imm),
      .o_cmd_ack  (o_cmd_ack),
      .cmd        (cmd_if)
   );

   // lanes run independently, several operations may be in flight
   for (genvar g = 0; g < N_LANES; g++) begin : g_lane
      serial_lane #(
         .RAM_W (RAM_W)
      ) serial_lane_inst (
         .i_clk (i_clk),
         .i_rst (i_rst),
         .cmd   (cmd_if[g]),
         .res   (res_if[g])
      );
   end

   result_collect #(
      .N_LANES (N_LANES)
   ) result_collect_inst (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .res        (res_if),
      .o_res_req  (o_res_req),
      .i_res_ack  (i_res_ack),
      .o_res_lane (o_res_lane),
      .o_res_data (o_res_data)
   );

endmodule

/* verif/tb_serial_rf.sv */
`timescale 1ns/1ps

module tb_serial_rf;
   import serial_rf_pkg::*;

   localparam int N_LANES = 4;
   localparam int LANE_W  = $clog2(N_LANES);
   localparam int N_RAND  = 400;
   // ldi/rd sweep, lane independence, random mix, final readout
   localparam int N_CMDS  = 2 * N_LANES * 32 + 2 * N_LANES + N_RAND + N_LANES * 32;
   localparam int TIMEOUT = N_CMDS * 200 + 1000;
   localparam int DRAIN_LIMIT = 2000;

   typedef logic [LANE_W-1:0] lane_id_t;

   logic     i_clk;
   logic     i_rst;
   logic     i_cmd_req;
   lane_id_t i_cmd_lane;
   op_t      i_cmd_op;
   reg_idx_t i_cmd_rd;
   reg_idx_t i_cmd_rs1;
   reg_idx_t i_cmd_rs2;
   word_t    i_cmd_imm;
   logic     o_cmd_ack;
   logic     o_res_req;
   lane_id_t o_res_lane;
   word_t    o_res_data;
   logic     i_res_ack;

   integer   seed;
   int       cycle_cnt = 0;
   int       max_ack_delay;
   int       n_mismatch;
   int       n_unexpected;
   int       n_protocol;
   int       n_missing;
   lane_id_t last_res_lane;

   // reference model, register contents and pending read-outs per lane
   word_t    model_rf [N_LANES][32];
   word_t    exp_q [N_LANES][$];
   string    name_q [N_LANES][$];

   serial_rf_top serial_rf_top_inst (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_cmd_req  (i_cmd_req),
      .i_cmd_lane (i_cmd_lane),
      .i_cmd_op   (i_cmd_op),
      .i_cmd_rd   (i_cmd_rd),
      .i_cmd_rs1  (i_cmd_rs1),
      .i_cmd_rs2  (i_cmd_rs2),
      .i_cmd_imm  (i_cmd_imm),
      .o_cmd_ack  (o_cmd_ack),
      .o_res_req  (o_res_req),
      .o_res_lane (o_res_lane),
      .o_res_data (o_res_data),
      .i_res_ack  (i_res_ack)
   );

   always #2 i_clk = ~i_clk;

   function automatic int unsigned rand_below(int unsigned n);
      return {$random(seed)} % n;
   endfunction

   function automatic int pending_results();
      int total;
      total = 0;
      for (int l = 0; l < N_LANES; l++) begin
         total += exp_q[l].size();
      end
      return total;
   endfunction

   task automatic check_word(string name, word_t exp, word_t act);
      if (exp !== act) begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         n_mismatch++;
      end
   endtask

   task automatic check_lane(string name, lane_id_t exp, lane_id_t act);
      if (exp !== act) begin
         $display("ERROR %s: expected lane %0d, actual lane %0d", name, exp, act);
         n_mismatch++;
      end
   endtask

   task automatic next_cycle();
      @(posedge i_clk);
      #1;
   endtask

   // update the model, then run the four-phase command handshake
   task automatic issue(lane_id_t lane, op_t op, reg_idx_t rd, reg_idx_t rs1,
                        reg_idx_t rs2, word_t imm, string name);
      case (op)
         OP_LDI: model_rf[lane][rd] = imm;
         OP_ADD: model_rf[lane][rd] = model_rf[lane][rs1] + model_rf[lane][rs2];
         OP_XOR: model_rf[lane][rd] = model_rf[lane][rs1] ^ model_rf[lane][rs2];
         default: begin
            exp_q[lane].push_back(model_rf[lane][rs1]);
            name_q[lane].push_back(name);
         end
      endcase
      i_cmd_lane = lane;
      i_cmd_op   = op;
      i_cmd_rd   = rd;
      i_cmd_rs1  = rs1;
      i_cmd_rs2  = rs2;
      i_cmd_imm  = imm;
      i_cmd_req  = 1'b1;
      do begin
         next_cycle();
      end while (!o_cmd_ack);
      i_cmd_req = 1'b0;
      do begin
         next_cycle();
      end while (o_cmd_ack);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((pending_results() != 0 || o_res_req || i_res_ack) && waited < DRAIN_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (waited >= DRAIN_LIMIT) begin
         $display("results still pending after %0d cycles, a result was lost", DRAIN_LIMIT);
         n_protocol++;
      end
   endtask

   // result side, acks each result after a random delay
   initial begin
      lane_id_t lane;
      word_t    data;
      int       delay;
      wait (i_rst === 1'b0);
      forever begin
         next_cycle();
         if (o_res_req && !i_res_ack) begin
            lane = o_res_lane;
            data = o_res_data;
            last_res_lane = lane;
            if (exp_q[lane].size() == 0) begin
               $display("unexpected result %h on lane %0d with nothing pending", data, lane);
               n_unexpected++;
            end else begin
               check_word(name_q[lane].pop_front(), exp_q[lane].pop_front(), data);
            end
            delay = rand_below(max_ack_delay + 1);
            repeat (delay) begin
               next_cycle();
            end
            check_word("res_hold", data, o_res_data);
            check_lane("res_hold", lane, o_res_lane);
            i_res_ack = 1'b1;
            do begin
               next_cycle();
            end while (o_res_req);
            i_res_ack = 1'b0;
         end
      end
   end

   always @(posedge i_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT) begin
         $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      reg_idx_t r;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      lane_id_t lane;
      op_t      op;
      word_t    base;
      int       alias_sel;

      i_clk      = 1'b0;
      i_rst      = 1'b1;
      i_cmd_req  = 1'b0;
      i_cmd_lane = '0;
      i_cmd_op   = OP_LDI;
      i_cmd_rd   = '0;
      i_cmd_rs1  = '0;
      i_cmd_rs2  = '0;
      i_cmd_imm  = '0;
      i_res_ack  = 1'b0;
      seed          = 32'he02caf2c;
      max_ack_delay = 0;
      n_mismatch    = 0;
      n_unexpected  = 0;
      n_protocol    = 0;
      n_missing     = 0;
      last_res_lane = '0;

      repeat (2) @(posedge i_clk);
      #1;
      i_rst = 1'b0;

      // handshake outputs quiet until the first command
      repeat (6) begin
         if (o_cmd_ack !== 1'b0 || o_res_req !== 1'b0) begin
            $display("o_cmd_ack or o_res_req not low after reset");
            n_protocol++;
         end
         next_cycle();
      end

      // load and read back every register of every lane
      for (int i = 0; i < 32; i++) begin
         r = reg_idx_t'(i);
         for (int l = 0; l < N_LANES; l++) begin
            issue(lane_id_t'(l), OP_LDI, r, '0, '0, word_t'($random(seed)), "ldi_rd");
         end
         for (int l = 0; l < N_LANES; l++) begin
            issue(lane_id_t'(l), OP_RD, '0, r, '0, '0, "ldi_rd");
         end
      end
      wait_drain();

      // same index, different value per lane
      r    = reg_idx_t'(rand_below(32));
      base = word_t'($random(seed));
      for (int l = 0; l < N_LANES; l++) begin
         issue(lane_id_t'(l), OP_LDI, r, '0, '0, base + word_t'(l) * 32'h0100_0001,
               "lane_indep");
      end
      for (int l = 0; l < N_LANES; l++) begin
         issue(lane_id_t'(l), OP_RD, '0, r, '0, '0, "lane_indep");
         wait_drain();
         check_lane("lane_indep", lane_id_t'(l), last_res_lane);
      end

      // random mix under output back-pressure
      max_ack_delay = 7;
      for (int n = 0; n < N_RAND; n++) begin
         repeat (rand_below(4)) begin
            next_cycle();
         end
         lane = lane_id_t'(rand_below(N_LANES));
         op   = op_t'(rand_below(4));
         rs1  = reg_idx_t'(rand_below(32));
         rs2  = reg_idx_t'(rand_below(32));
         alias_sel = rand_below(4);
         if (alias_sel == 0) begin
            rd = rs1;
         end else if (alias_sel == 1) begin
            rd = rs2;
         end else begin
            rd = reg_idx_t'(rand_below(32));
         end
         issue(lane, op, rd, rs1, rs2, word_t'($random(seed)), "random");
      end
      wait_drain();

      // every add and xor result is visible in the final register state
      max_ack_delay = 3;
      for (int i = 0; i < 32; i++) begin
         for (int l = 0; l < N_LANES; l++) begin
            issue(lane_id_t'(l), OP_RD, '0, reg_idx_t'(i), '0, '0, "final_rd");
         end
      end
      wait_drain();

      for (int l = 0; l < N_LANES; l++) begin
         if (exp_q[l].size() != 0) begin
            $display("lane %0d never returned %0d expected results", l, exp_q[l].size());
            n_missing += exp_q[l].size();
         end
      end

      $display("errors: mismatch %0d, unexpected %0d, protocol %0d, missing %0d",
               n_mismatch, n_unexpected, n_protocol, n_missing);
      if (n_mismatch + n_unexpected + n_protocol + n_missing == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
